// ==== hdl/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN       = 32;  // data and address width
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int DMEM_WORDS = 256; // data memory depth in words

    localparam logic [XLEN-1:0] RESET_PC  = 32'h0000_0000;
    localparam logic [XLEN-1:0] PC_STEP   = 32'd4;
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013; // addi x0,x0,0

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b011_0011;
    localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
    localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
    localparam logic [6:0] OPC_STORE  = 7'b010_0011;
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
    localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;

    // funct3 codes
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_LW_SW   = 3'b010; // word access only

    // alu operation codes
    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_SUB = 3'd1;
    localparam logic [2:0] ALU_AND = 3'd2;
    localparam logic [2:0] ALU_OR  = 3'd3;
    localparam logic [2:0] ALU_XOR = 3'd4;
    localparam logic [2:0] ALU_SLT = 3'd5;

    // ecall halts when a7 holds 10
    localparam logic [REG_ADDR_W-1:0] HALT_REG  = 5'd17;
    localparam logic [XLEN-1:0]       HALT_CODE = 32'd10;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_hi; // imm[11:5]
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo; // imm[4:0]
        logic [6:0]            opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                  imm12;
        logic [5:0]            imm10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm4_1;
        logic                  imm11;
        logic [6:0]            opcode;
    } b_fmt_t;

    // one instruction word, four field layouts
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
    } instr_u;

endpackage

// ==== hdl/ex_mem_if.sv ====
`timescale 1ns/10ps

interface ex_mem_if;
    logic [rv_pkg::XLEN-1:0]       alu_result; // alu value or data address
    logic [rv_pkg::XLEN-1:0]       store_data; // forwarded rs2
    logic [rv_pkg::REG_ADDR_W-1:0] rd;
    logic                          reg_write;
    logic                          mem_read;
    logic                          mem_write;
    logic                          halt;       // halting ecall in flight

    modport execute (
        output alu_result, store_data, rd, reg_write, mem_read, mem_write, halt
    );

    modport memory (
        input alu_result, store_data, rd, reg_write, mem_read, mem_write, halt
    );

    // ecall check in decode
    modport hazard (
        input rd, reg_write, mem_read
    );

endinterface

// ==== hdl/reg_file.sv ====
`timescale 1ns/10ps

module reg_file (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2,
    input  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
    input  logic                          wb_we,
    input  logic [rv_pkg::XLEN-1:0]       wb_data,
    output logic [rv_pkg::XLEN-1:0]       rs1_data,
    output logic [rv_pkg::XLEN-1:0]       rs2_data,
    output logic [rv_pkg::XLEN-1:0]       reg_view [rv_pkg::NUM_REGS]
);
    logic [rv_pkg::XLEN-1:0] regs [rv_pkg::NUM_REGS];
    logic                    wr_ok;

    assign wr_ok = wb_we && (wb_rd != '0); // x0 writes dropped

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // same-cycle writeback passes straight through
    assign rs1_data = (rs1 == '0) ? '0 : (wr_ok && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : (wr_ok && wb_rd == rs2) ? wb_data : regs[rs2];

    always_comb begin
        reg_view = regs; // x0 never written, keeps its reset zero
    end

endmodule

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/10ps

module fetch_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [rv_pkg::XLEN-1:0] imem_data,
    input  logic                    stall,       // load-use or ecall wait
    input  logic                    redirect,    // taken branch in execute
    input  logic [rv_pkg::XLEN-1:0] redirect_pc,
    output logic [rv_pkg::XLEN-1:0] imem_addr,
    output logic [rv_pkg::XLEN-1:0] if_instr,
    output logic [rv_pkg::XLEN-1:0] if_pc
);
    logic [rv_pkg::XLEN-1:0] pc;

    assign imem_addr = pc;

    // pc counter, redirect beats stall
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= rv_pkg::RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc + rv_pkg::PC_STEP;
        end
    end

    // fetch/decode register
    always_ff @(posedge clk) begin
        if (reset || redirect) begin
            if_instr <= rv_pkg::NOP_INSTR; // squash wrong-path fetch
        end else if (!stall) begin
            if_instr <= imem_data;
            if_pc    <= pc;
        end
    end

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [rv_pkg::XLEN-1:0]       if_instr,
    input  logic [rv_pkg::XLEN-1:0]       if_pc,
    input  logic                          redirect,
    input  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
    input  logic                          wb_we,
    input  logic [rv_pkg::XLEN-1:0]       wb_data,
    output logic                          stall,
    ex_mem_if.hazard                      ex_mem,
    output logic [rv_pkg::XLEN-1:0]       id_pc,
    output logic [rv_pkg::REG_ADDR_W-1:0] id_rs1,
    output logic [rv_pkg::REG_ADDR_W-1:0] id_rs2,
    output logic [rv_pkg::XLEN-1:0]       id_rs1_data,
    output logic [rv_pkg::XLEN-1:0]       id_rs2_data,
    output logic [rv_pkg::XLEN-1:0]       id_imm,
    output logic [2:0]                    id_alu_op,
    output logic                          id_alu_src,
    output logic                          id_branch,
    output logic                          id_bne,
    output logic                          id_mem_read,
    output logic                          id_mem_write,
    output logic                          id_reg_write,
    output logic [rv_pkg::REG_ADDR_W-1:0] id_rd,
    output logic                          id_halt,
    output logic [rv_pkg::XLEN-1:0]       reg_view [rv_pkg::NUM_REGS]
);
    rv_pkg::instr_u                instr;
    logic [rv_pkg::REG_ADDR_W-1:0] rs1;
    logic [rv_pkg::XLEN-1:0]       rs1_data;
    logic [rv_pkg::XLEN-1:0]       rs2_data;
    logic [rv_pkg::XLEN-1:0]       imm;
    logic [2:0]                    alu_op;
    logic [2:0]                    f3_op;     // alu op implied by funct3
    logic                          f3_ok;
    logic                          alu_src;
    logic                          branch;
    logic                          mem_read;
    logic                          mem_write;
    logic                          reg_write;
    logic                          is_ecall;
    logic                          uses_rs2;
    logic                          load_use;
    logic                          ecall_wait;
    logic                          halt;
    logic                          halt_seen; // halting ecall already issued
    logic                          bubble;

    assign instr = if_instr;
    assign rs1   = is_ecall ? rv_pkg::HALT_REG : instr.r.rs1; // ecall peeks at x17

    reg_file rf_i (
        .clk, .reset,
        .rs1, .rs2 (instr.r.rs2),
        .wb_rd, .wb_we, .wb_data,
        .rs1_data, .rs2_data,
        .reg_view
    );

    always_comb begin
        alu_op    = rv_pkg::ALU_ADD;
        alu_src   = 1'b0;
        branch    = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        is_ecall  = 1'b0;
        uses_rs2  = 1'b0;
        imm       = {{20{instr.i.imm[11]}}, instr.i.imm}; // I form unless overridden
        f3_ok     = 1'b1;
        case (instr.r.funct3) // shared by reg and imm forms
            rv_pkg::F3_ADD_SUB: f3_op = rv_pkg::ALU_ADD;
            rv_pkg::F3_SLT:     f3_op = rv_pkg::ALU_SLT;
            rv_pkg::F3_XOR:     f3_op = rv_pkg::ALU_XOR;
            rv_pkg::F3_OR:      f3_op = rv_pkg::ALU_OR;
            rv_pkg::F3_AND:     f3_op = rv_pkg::ALU_AND;
            default: begin
                f3_op = rv_pkg::ALU_ADD;
                f3_ok = 1'b0; // shifts not supported
            end
        endcase
        case (instr.r.opcode)
            rv_pkg::OPC_OP: begin
                reg_write = f3_ok;
                uses_rs2  = 1'b1;
                alu_op    = (instr.r.funct3 == rv_pkg::F3_ADD_SUB && instr.r.funct7[5])
                            ? rv_pkg::ALU_SUB : f3_op;
            end
            rv_pkg::OPC_OP_IMM: begin
                reg_write = f3_ok;
                alu_src   = 1'b1;
                alu_op    = f3_op;
            end
            rv_pkg::OPC_LOAD: begin
                mem_read  = (instr.i.funct3 == rv_pkg::F3_LW_SW);
                reg_write = mem_read;
                alu_src   = 1'b1;
            end
            rv_pkg::OPC_STORE: begin
                mem_write = (instr.s.funct3 == rv_pkg::F3_LW_SW);
                alu_src   = 1'b1;
                uses_rs2  = 1'b1;
                imm       = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            end
            rv_pkg::OPC_BRANCH: begin
                branch   = (instr.b.funct3 == rv_pkg::F3_BEQ) ||
                           (instr.b.funct3 == rv_pkg::F3_BNE);
                uses_rs2 = 1'b1;
                imm      = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                            instr.b.imm10_5, instr.b.imm4_1, 1'b0};
            end
            rv_pkg::OPC_SYSTEM: is_ecall = 1'b1;
            default: ;
        endcase
    end

    // load in execute feeding this instruction
    assign load_use = id_mem_read && (id_rd != '0) &&
                      ((id_rd == rs1) || (uses_rs2 && id_rd == instr.r.rs2));
    // x17 still being produced downstream, loads count as writers too
    assign ecall_wait = is_ecall &&
                        ((id_reg_write && id_rd == rv_pkg::HALT_REG) ||
                         ((ex_mem.reg_write || ex_mem.mem_read) &&
                          ex_mem.rd == rv_pkg::HALT_REG));
    assign stall  = load_use || ecall_wait;
    assign halt   = is_ecall && (rs1_data == rv_pkg::HALT_CODE);
    assign bubble = stall || redirect || halt_seen;

    always_ff @(posedge clk) begin
        if (reset) begin
            halt_seen <= 1'b0;
        end else if (halt && !bubble) begin
            halt_seen <= 1'b1; // only bubbles from here on
        end
    end

    // decode/execute register
    always_ff @(posedge clk) begin
        id_pc       <= if_pc;
        id_rs1      <= rs1;
        id_rs2      <= instr.r.rs2;
        id_rs1_data <= rs1_data;
        id_rs2_data <= rs2_data;
        id_imm      <= imm;
        id_alu_op   <= alu_op;
        id_alu_src  <= alu_src;
        id_bne      <= (instr.b.funct3 == rv_pkg::F3_BNE);
        id_rd       <= instr.r.rd;
        if (reset || bubble) begin
            id_branch    <= 1'b0;
            id_mem_read  <= 1'b0;
            id_mem_write <= 1'b0;
            id_reg_write <= 1'b0;
            id_halt      <= 1'b0;
        end else begin
            id_branch    <= branch;
            id_mem_read  <= mem_read;
            id_mem_write <= mem_write;
            id_reg_write <= reg_write;
            id_halt      <= halt;
        end
    end

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [rv_pkg::XLEN-1:0]       id_pc,
    input  logic [rv_pkg::REG_ADDR_W-1:0] id_rs1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] id_rs2,
    input  logic [rv_pkg::XLEN-1:0]       id_rs1_data,
    input  logic [rv_pkg::XLEN-1:0]       id_rs2_data,
    input  logic [rv_pkg::XLEN-1:0]       id_imm,
    input  logic [2:0]                    id_alu_op,
    input  logic                          id_alu_src,
    input  logic                          id_branch,
    input  logic                          id_bne,
    input  logic                          id_mem_read,
    input  logic                          id_mem_write,
    input  logic                          id_reg_write,
    input  logic [rv_pkg::REG_ADDR_W-1:0] id_rd,
    input  logic                          id_halt,
    input  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
    input  logic                          wb_we,
    input  logic [rv_pkg::XLEN-1:0]       wb_data,
    output logic                          redirect,
    output logic [rv_pkg::XLEN-1:0]       redirect_pc,
    ex_mem_if.execute                     ex_mem
);
    logic [rv_pkg::XLEN-1:0] fwd_a;
    logic [rv_pkg::XLEN-1:0] fwd_b; // also the store data
    logic [rv_pkg::XLEN-1:0] op_b;
    logic [rv_pkg::XLEN-1:0] alu_y;

    // youngest producer first, x0 never matches
    function automatic logic [rv_pkg::XLEN-1:0] forward(
        input logic [rv_pkg::REG_ADDR_W-1:0] rs,
        input logic [rv_pkg::XLEN-1:0]       id_val
    );
        if (ex_mem.reg_write && ex_mem.rd != '0 && ex_mem.rd == rs) begin
            return ex_mem.alu_result;
        end
        if (wb_we && wb_rd != '0 && wb_rd == rs) begin
            return wb_data;
        end
        return id_val;
    endfunction

    assign fwd_a = forward(id_rs1, id_rs1_data);
    assign fwd_b = forward(id_rs2, id_rs2_data);
    assign op_b  = id_alu_src ? id_imm : fwd_b;

    always_comb begin
        case (id_alu_op)
            rv_pkg::ALU_SUB: alu_y = fwd_a - op_b;
            rv_pkg::ALU_AND: alu_y = fwd_a & op_b;
            rv_pkg::ALU_OR:  alu_y = fwd_a | op_b;
            rv_pkg::ALU_XOR: alu_y = fwd_a ^ op_b;
            rv_pkg::ALU_SLT: alu_y = ($signed(fwd_a) < $signed(op_b)) ? 32'd1 : '0;
            default:         alu_y = fwd_a + op_b;
        endcase
    end

    // not-taken prediction, resolve here
    assign redirect    = id_branch && ((fwd_a == fwd_b) != id_bne);
    assign redirect_pc = id_pc + id_imm;

    // execute/memory register
    always_ff @(posedge clk) begin
        ex_mem.alu_result <= alu_y;
        ex_mem.store_data <= fwd_b;
        ex_mem.rd         <= id_rd;
        if (reset) begin
            ex_mem.reg_write <= 1'b0;
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
            ex_mem.halt      <= 1'b0;
        end else begin
            ex_mem.reg_write <= id_reg_write;
            ex_mem.mem_read  <= id_mem_read;
            ex_mem.mem_write <= id_mem_write;
            ex_mem.halt      <= id_halt;
        end
    end

endmodule

// ==== hdl/mem_stage.sv ====
`timescale 1ns/10ps

module mem_stage (
    input  logic                          clk,
    input  logic                          reset,
    ex_mem_if.memory                      ex_mem,
    output logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic                          wb_we,
    output logic [rv_pkg::XLEN-1:0]       wb_data,
    output logic                          halted
);
    logic [rv_pkg::XLEN-1:0]               dmem [rv_pkg::DMEM_WORDS];
    logic [$clog2(rv_pkg::DMEM_WORDS)-1:0] word_idx;
    logic [rv_pkg::XLEN-1:0]               load_data;

    // byte address to word index
    assign word_idx  = ex_mem.alu_result[$clog2(rv_pkg::DMEM_WORDS)+1:2];
    assign load_data = dmem[word_idx]; // async read

    always_ff @(posedge clk) begin
        if (ex_mem.mem_write) begin
            dmem[word_idx] <= ex_mem.store_data;
        end
    end

    // memory/writeback register and sticky halt
    always_ff @(posedge clk) begin
        wb_rd   <= ex_mem.rd;
        wb_data <= ex_mem.mem_read ? load_data : ex_mem.alu_result;
        if (reset) begin
            wb_we  <= 1'b0;
            halted <= 1'b0;
        end else begin
            wb_we  <= ex_mem.reg_write;
            halted <= halted || ex_mem.halt; // held until reset
        end
    end

endmodule

// ==== hdl/pipe_cpu.sv ====
`timescale 1ns/10ps

module pipe_cpu (
    input  logic                    clk,
    input  logic                    reset,
    output logic [rv_pkg::XLEN-1:0] imem_addr,
    input  logic [rv_pkg::XLEN-1:0] imem_data,   // combinational imem answer
    output logic                    halted,
    output logic [rv_pkg::XLEN-1:0] reg_view [rv_pkg::NUM_REGS]
);
    // fetch <-> decode
    logic [rv_pkg::XLEN-1:0]       if_instr;
    logic [rv_pkg::XLEN-1:0]       if_pc;
    logic                          stall;
    // execute -> fetch, decode
    logic                          redirect;
    logic [rv_pkg::XLEN-1:0]       redirect_pc;
    // decode/execute register
    logic [rv_pkg::XLEN-1:0]       id_pc;
    logic [rv_pkg::REG_ADDR_W-1:0] id_rs1;
    logic [rv_pkg::REG_ADDR_W-1:0] id_rs2;
    logic [rv_pkg::XLEN-1:0]       id_rs1_data;
    logic [rv_pkg::XLEN-1:0]       id_rs2_data;
    logic [rv_pkg::XLEN-1:0]       id_imm;
    logic [2:0]                    id_alu_op;
    logic                          id_alu_src;
    logic                          id_branch;
    logic                          id_bne;
    logic                          id_mem_read;
    logic                          id_mem_write;
    logic                          id_reg_write;
    logic [rv_pkg::REG_ADDR_W-1:0] id_rd;
    logic                          id_halt;
    // writeback
    logic [rv_pkg::REG_ADDR_W-1:0] wb_rd;
    logic                          wb_we;
    logic [rv_pkg::XLEN-1:0]       wb_data;

    ex_mem_if ex_mem ();

    fetch_unit fetch_i (
        .clk, .reset,
        .imem_data, .stall, .redirect, .redirect_pc,
        .imem_addr, .if_instr, .if_pc
    );

    decode_stage decode_i (
        .clk, .reset,
        .if_instr, .if_pc, .redirect,
        .wb_rd, .wb_we, .wb_data,
        .stall,
        .ex_mem (ex_mem.hazard),
        .id_pc, .id_rs1, .id_rs2, .id_rs1_data, .id_rs2_data, .id_imm,
        .id_alu_op, .id_alu_src, .id_branch, .id_bne,
        .id_mem_read, .id_mem_write, .id_reg_write, .id_rd, .id_halt,
        .reg_view
    );

    execute_stage execute_i (
        .clk, .reset,
        .id_pc, .id_rs1, .id_rs2, .id_rs1_data, .id_rs2_data, .id_imm,
        .id_alu_op, .id_alu_src, .id_branch, .id_bne,
        .id_mem_read, .id_mem_write, .id_reg_write, .id_rd, .id_halt,
        .wb_rd, .wb_we, .wb_data,
        .redirect, .redirect_pc,
        .ex_mem (ex_mem.execute)
    );

    mem_stage mem_i (
        .clk, .reset,
        .ex_mem (ex_mem.memory),
        .wb_rd, .wb_we, .wb_data,
        .halted
    );

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    // 4 ns period
    always begin
        #2 clk = ~clk;
    end

endmodule

// ==== tb/pipe_cpu_properties.sv ====
`timescale 1ns/10ps

module pipe_cpu_properties (
    input logic                    clk,
    input logic                    reset,
    input logic [rv_pkg::XLEN-1:0] imem_addr,
    input logic                    halted,
    input logic [rv_pkg::XLEN-1:0] reg_zero,  // reg_view entry 0
    input logic                    stall,
    input logic                    redirect
);
    int fail_count = 0; // failed assertion tally

    // pc back at the start, halt cleared
    reset_state: assert property (@(posedge clk)
        reset |=> (imem_addr == rv_pkg::RESET_PC) && !halted)
        else begin
            $error("pc or halted not in reset state after reset");
            fail_count++;
        end

    zero_reg: assert property (@(posedge clk) disable iff (reset) reg_zero == '0)
        else begin
            $error("x0 reads nonzero");
            fail_count++;
        end

    // sticky until reset
    halt_held: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
        else begin
            $error("halted fell without reset");
            fail_count++;
        end

    // sequential fetch unless held or redirected
    pc_step: assert property (@(posedge clk) disable iff (reset)
        !stall && !redirect |=> imem_addr == $past(imem_addr) + rv_pkg::PC_STEP)
        else begin
            $error("fetch address did not step by one word");
            fail_count++;
        end

endmodule

bind pipe_cpu pipe_cpu_properties props_i (
    .clk, .reset, .imem_addr, .halted,
    .reg_zero (reg_view[0]),
    .stall, .redirect
);

// ==== tb/pipe_cpu_tb.sv ====
`timescale 1ns/10ps

module pipe_cpu_tb;
    logic                    clk;
    logic                    reset;
    logic [rv_pkg::XLEN-1:0] imem_addr;
    logic [rv_pkg::XLEN-1:0] imem_data;
    logic                    halted;
    logic [rv_pkg::XLEN-1:0] reg_view [rv_pkg::NUM_REGS];

    logic [31:0] imem [256];                 // program words
    logic [31:0] exp_reg [rv_pkg::NUM_REGS]; // isa model of the register file
    logic [31:0] exp_mem [rv_pkg::DMEM_WORDS];
    int          prog_len;
    int          skip_left;                  // words jumped over by a taken branch
    bit          model_halted;
    int          checks_failed;
    int          tests_run;
    int          tests_failed;
    logic [11:0] rnd [5];

    tb_clock clock_i (.clk);

    pipe_cpu dut_i (.clk, .reset, .imem_addr, .imem_data, .halted, .reg_view);

    assign imem_data = imem[imem_addr[9:2]]; // same-cycle answer

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // rv32i result rules
    function automatic logic [31:0] isa_alu(input logic [2:0] f3, input bit sub,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            rv_pkg::F3_ADD_SUB: return sub ? a - b : a + b;
            rv_pkg::F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rv_pkg::F3_XOR:     return a ^ b;
            rv_pkg::F3_OR:      return a | b;
            default:            return a & b;
        endcase
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        rv_pkg::instr_u w;
        w.i = '{imm: imm, rs1: rs1, funct3: f3, rd: rd, opcode: opc};
        return w;
    endfunction

    function automatic void clear_program();
        for (int i = 0; i < 256; i++) begin
            imem[i] = rv_pkg::NOP_INSTR;
        end
    endfunction

    // live is low for squashed words and anything after a halt
    task automatic append_word(input logic [31:0] word, output bit live);
        imem[prog_len] = word;
        prog_len++;
        live = !model_halted && skip_left == 0;
        if (skip_left > 0) begin
            skip_left--;
        end
    endtask

    task automatic reg_alu(input logic [2:0] f3, input bit sub, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [4:0] rs2);
        rv_pkg::instr_u w;
        bit             live;
        w.r = '{funct7: {1'b0, sub, 5'd0}, rs2: rs2, rs1: rs1, funct3: f3, rd: rd,
                opcode: rv_pkg::OPC_OP};
        append_word(w, live);
        if (live && rd != 0) begin
            exp_reg[rd] = isa_alu(f3, sub, exp_reg[rs1], exp_reg[rs2]);
        end
    endtask

    task automatic imm_alu(input logic [2:0] f3, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [11:0] imm);
        bit live;
        append_word(i_word(imm, rs1, f3, rd, rv_pkg::OPC_OP_IMM), live);
        if (live && rd != 0) begin
            exp_reg[rd] = isa_alu(f3, 1'b0, exp_reg[rs1], sext12(imm));
        end
    endtask

    task automatic store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                              input logic [11:0] imm);
        rv_pkg::instr_u w;
        bit             live;
        logic [31:0]    addr;
        w.s = '{imm_hi: imm[11:5], rs2: rs2, rs1: rs1, funct3: rv_pkg::F3_LW_SW,
                imm_lo: imm[4:0], opcode: rv_pkg::OPC_STORE};
        append_word(w, live);
        addr = exp_reg[rs1] + sext12(imm);
        if (live) begin
            exp_mem[addr[9:2]] = exp_reg[rs2]; // word index
        end
    endtask

    task automatic load_word(input logic [4:0] rd, input logic [4:0] rs1,
                             input logic [11:0] imm);
        bit          live;
        logic [31:0] addr;
        append_word(i_word(imm, rs1, rv_pkg::F3_LW_SW, rd, rv_pkg::OPC_LOAD), live);
        addr = exp_reg[rs1] + sext12(imm);
        if (live && rd != 0) begin
            exp_reg[rd] = exp_mem[addr[9:2]];
        end
    endtask

    // forward branch over skip words
    task automatic branch_if(input bit bne, input logic [4:0] rs1, input logic [4:0] rs2,
                             input int skip);
        rv_pkg::instr_u w;
        bit             live;
        logic [12:0]    off;
        off = 13'((skip + 1) * 4);
        w.b = '{imm12: off[12], imm10_5: off[10:5], rs2: rs2, rs1: rs1,
                funct3: bne ? rv_pkg::F3_BNE : rv_pkg::F3_BEQ, imm4_1: off[4:1],
                imm11: off[11], opcode: rv_pkg::OPC_BRANCH};
        append_word(w, live);
        if (live && ((exp_reg[rs1] == exp_reg[rs2]) != bne)) begin
            skip_left = skip;
        end
    endtask

    task automatic halt_call();
        bit live;
        append_word(i_word(12'd0, 5'd0, 3'd0, 5'd0, rv_pkg::OPC_SYSTEM), live);
        if (live && exp_reg[rv_pkg::HALT_REG] == rv_pkg::HALT_CODE) begin
            model_halted = 1'b1;
        end
    endtask

    // a7 = 10 right before the ecall
    task automatic request_halt();
        imm_alu(rv_pkg::F3_ADD_SUB, rv_pkg::HALT_REG, 5'd0, 12'(rv_pkg::HALT_CODE));
        halt_call();
    endtask

    task automatic begin_program();
        @(posedge clk);
        reset <= 1'b1;
        clear_program();
        for (int r = 0; r < rv_pkg::NUM_REGS; r++) begin
            exp_reg[r] = '0;
        end
        prog_len     = 0;
        skip_left    = 0;
        model_halted = 1'b0;
    endtask

    task automatic run_and_check(input string name);
        int waited;
        int fails_before;
        fails_before = checks_failed;
        repeat (16) @(posedge clk); // reset held 16 cycles
        reset  <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!halted && waited < 500) begin
            @(negedge clk);
            waited++;
        end
        if (!halted) begin
            $display("%s: halted did not rise within 500 cycles", name);
            checks_failed++;
        end else begin
            for (int k = 0; k < 12; k++) begin // must hold while the tail drains
                @(negedge clk);
                assert (halted) else begin
                    $display("%s: halted dropped after rising", name);
                    checks_failed++;
                end
            end
            for (int r = 0; r < rv_pkg::NUM_REGS; r++) begin
                assert (reg_view[r] === exp_reg[r]) else begin
                    $display("error %s x%0d expected %h actual %h",
                             name, r, exp_reg[r], reg_view[r]);
                    checks_failed++;
                end
            end
        end
        tests_run++;
        if (checks_failed != fails_before) begin
            tests_failed++;
        end
        $display("%-10s %s", name, (checks_failed == fails_before) ? "ok" : "FAILED");
    endtask

    initial begin
        logic [11:0] addr;
        void'($urandom(32'h6e92_4519));
        reset         = 1'b1;
        checks_failed = 0;
        tests_run     = 0;
        tests_failed  = 0;
        clear_program();
        for (int k = 0; k < 5; k++) begin
            rnd[k] = 12'($urandom);
        end

        // dependent chain, mem and wb forwarding
        begin_program();
        imm_alu(rv_pkg::F3_ADD_SUB, 5'd1, 5'd0, rnd[0]);
        imm_alu(rv_pkg::F3_ADD_SUB, 5'd2, 5'd1, rnd[1]);
        reg_alu(rv_pkg::F3_ADD_SUB, 1'b0, 5'd3, 5'd1, 5'd2);
        reg_alu(rv_pkg::F3_ADD_SUB, 1'b1, 5'd4, 5'd3, 5'd1);
        imm_alu(rv_pkg::F3_XOR, 5'd5, 5'd4, rnd[2]);
        reg_alu(rv_pkg::F3_AND, 1'b0, 5'd6, 5'd5, 5'd3);
        reg_alu(rv_pkg::F3_OR, 1'b0, 5'd7, 5'd6, 5'd2);
        reg_alu(rv_pkg::F3_SLT, 1'b0, 5'd8, 5'd4, 5'd1);
        imm_alu(rv_pkg::F3_SLT, 5'd9, 5'd5, rnd[3]);
        imm_alu(rv_pkg::F3_AND, 5'd10, 5'd7, rnd[4]);
        imm_alu(rv_pkg::F3_OR, 5'd11, 5'd10, rnd[0]);
        reg_alu(rv_pkg::F3_XOR, 1'b0, 5'd12, 5'd11, 5'd9);
        request_halt();
        run_and_check("alu_chain");

        // store, load, then use the load at once
        addr = 12'($urandom_range(0, 200) * 4);
        begin_program();
        imm_alu(rv_pkg::F3_ADD_SUB, 5'd1, 5'd0, addr);
        imm_alu(rv_pkg::F3_ADD_SUB, 5'd2, 5'd0, rnd[1]);
        store_word(5'd2, 5'd1, 12'd4);
        load_word(5'd3, 5'd1, 12'd4);
        reg_alu(rv_pkg::F3_ADD_SUB, 1'b0, 5'd4, 5'd3, 5'd2);
        load_word(5'd5, 5'd1, 12'd4);
        imm_alu(rv_pkg::F3_XOR, 5'd6, 5'd5, rnd[2]);
        request_halt();
        run_and_check("load_use");

        begin_program();
        imm_alu(rv_pkg::F3_ADD_SUB, 5'd1, 5'd0, 12'd5);
        imm_alu(rv_pkg::F3_ADD_SUB, 5'd2, 5'd0, 12'd5);
        branch_if(1'b0, 5'd1, 5'd2, 2);                   // beq taken
        imm_alu(rv_pkg::F3_ADD_SUB, 5'd3, 5'd0, 12'd1);
        imm_alu(rv_pkg::F3_ADD_SUB, 5'd4, 5'd0, 12'd1);
        imm_alu(rv_pkg::F3_ADD_SUB, 5'd5, 5'd0, 12'd7);
        branch_if(1'b1, 5'd1, 5'd5, 2);                   // bne taken
        imm_alu(rv_pkg::F3_ADD_SUB, 5'd6, 5'd0, 12'd1);
        imm_alu(rv_pkg::F3_ADD_SUB, 5'd7, 5'd0, 12'd1);
        imm_alu(rv_pkg::F3_ADD_SUB, 5'd8, 5'd0, 12'd3);
        branch_if(1'b0, 5'd1, 5'd5, 1);                   // falls through
        imm_alu(rv_pkg::F3_ADD_SUB, 5'd9, 5'd0, 12'd9);
        branch_if(1'b1, 5'd1, 5'd2, 1);
        imm_alu(rv_pkg::F3_ADD_SUB, 5'd10, 5'd0, 12'd11);
        request_halt();
        run_and_check("branches");

        // ecall with a7 = 3 runs on, the second one stops
        begin_program();
        imm_alu(rv_pkg::F3_ADD_SUB, rv_pkg::HALT_REG, 5'd0, 12'd3);
        halt_call();
        imm_alu(rv_pkg::F3_ADD_SUB, 5'd20, 5'd0, 12'd1);
        request_halt();
        imm_alu(rv_pkg::F3_ADD_SUB, 5'd21, 5'd0, 12'd5);
        reg_alu(rv_pkg::F3_ADD_SUB, 1'b0, 5'd22, 5'd20, 5'd20);
        run_and_check("halt");

        $display("tests run %0d, with failures %0d, failed checks %0d, property failures %0d",
                 tests_run, tests_failed, checks_failed, dut_i.props_i.fail_count);
        if (checks_failed == 0 && dut_i.props_i.fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
hdl/rv_pkg.sv
hdl/ex_mem_if.sv
hdl/reg_file.sv
hdl/fetch_unit.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_stage.sv
hdl/pipe_cpu.sv
tb/tb_clock.sv
tb/pipe_cpu_properties.sv
tb/pipe_cpu_tb.sv

// ==== Bender.yml ====
package:
  name: pipe_cpu

sources:
  - files:
      - hdl/rv_pkg.sv
      - hdl/ex_mem_if.sv
      - hdl/reg_file.sv
      - hdl/fetch_unit.sv
      - hdl/decode_stage.sv
      - hdl/execute_stage.sv
      - hdl/mem_stage.sv
      - hdl/pipe_cpu.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/pipe_cpu_properties.sv
      - tb/pipe_cpu_tb.sv
